//--- rtl/vx_pkg.sv
package vx_pkg;

  localparam int XLEN   = 32;
  localparam int NLANES = 2;
  localparam int IMM_W  = 5;
  localparam int REG_W  = 5;

  typedef enum logic [2:0] {
    ALU_ADD  = 3'd0,
    ALU_AND  = 3'd1,
    ALU_OR   = 3'd2,
    ALU_XOR  = 3'd3,
    ALU_MIN  = 3'd4,
    ALU_MINU = 3'd5,
    ALU_MAX  = 3'd6,
    ALU_MAXU = 3'd7
  } alu_op_e;

  // operand-1 source, last code reads as zero
  typedef enum logic [1:0] {
    SRC_V = 2'd0,
    SRC_I = 2'd1,
    SRC_X = 2'd2,
    SRC_Z = 2'd3
  } src_e;

  typedef enum logic [1:0] {
    SEW8  = 2'd0,
    SEW16 = 2'd1,
    SEW32 = 2'd2
  } sew_e;

  typedef enum logic [1:0] {
    LS_UNIT    = 2'd0,
    LS_STRIDED = 2'd1,
    LS_INDEXED = 2'd2,
    LS_SEGMENT = 2'd3
  } ls_mode_e;

  typedef enum logic [1:0] {
    EEW8  = 2'd0,
    EEW16 = 2'd1,
    EEW32 = 2'd2
  } eew_e;

  // kind bit is the msb of both command views
  typedef struct packed {
    logic             kind;
    alu_op_e          aluop;
    src_e             src1;
    sew_e             sew;
    logic             reduce;
    logic             to_scalar;
    logic [IMM_W-1:0] imm;
    logic [REG_W-1:0] vd;
    logic [11:0]      pad;
  } alu_cmd_t;

  typedef struct packed {
    logic             kind;
    logic             is_store;
    ls_mode_e         mode;
    eew_e             eew;
    logic [2:0]       nf;
    logic [2:0]       nf_count;
    logic [REG_W-1:0] vd;
    logic [14:0]      pad;
  } mem_cmd_t;

  typedef union packed {
    alu_cmd_t alu;
    mem_cmd_t mem;
  } cmd_u;

  typedef struct packed {
    logic                         is_mem;
    logic                         is_store;
    alu_op_e                      aluop;
    sew_e                         sew;
    logic                         reduce;
    logic                         to_scalar;
    logic [REG_W-1:0]             vd;
    ls_mode_e                     mode;
    eew_e                         eew;
    logic [2:0]                   nf;
    logic [2:0]                   nf_count;
    logic [NLANES-1:0][XLEN-1:0]  op1;
    logic [NLANES-1:0][XLEN-1:0]  op2;
    logic [XLEN-1:0]              xs1;
    logic [XLEN-1:0]              xs2;
  } dec_t;

  typedef struct packed {
    logic [XLEN-1:0]  lane0;
    logic [XLEN-1:0]  lane1;
    logic             is_mem;
    logic             is_store;
    alu_op_e          aluop;
    sew_e             sew;
    logic             reduce;
    logic             to_scalar;
    logic [REG_W-1:0] vd;
  } exe_t;

  typedef struct packed {
    logic [XLEN-1:0]  data0;
    logic [XLEN-1:0]  data1;
    logic             is_mem;
    logic             is_store;
    logic [REG_W-1:0] vd;
    logic             rd_wen;
    logic [XLEN-1:0]  rd_data;
  } res_t;

endpackage

//--- rtl/vec_lane_alu.sv
module vec_lane_alu (
  input  vx_pkg::alu_op_e         aluop,
  input  vx_pkg::sew_e            sew,
  input  logic [vx_pkg::XLEN-1:0] a,
  input  logic [vx_pkg::XLEN-1:0] b,
  output logic [vx_pkg::XLEN-1:0] y
);

  logic lt_s;
  logic lt_u;

  // signed compare only looks at the active element width
  always_comb begin
    case (sew)
      vx_pkg::SEW8: begin
        lt_s = $signed(a[7:0]) < $signed(b[7:0]);
      end
      vx_pkg::SEW16: begin
        lt_s = $signed(a[15:0]) < $signed(b[15:0]);
      end
      default: begin
        lt_s = $signed(a) < $signed(b);
      end
    endcase
  end

  assign lt_u = a < b;

  always_comb begin
    case (aluop)
      vx_pkg::ALU_ADD: begin
        y = a + b;
      end
      vx_pkg::ALU_AND: begin
        y = a & b;
      end
      vx_pkg::ALU_OR: begin
        y = a | b;
      end
      vx_pkg::ALU_XOR: begin
        y = a ^ b;
      end
      // min/max hand back the whole winning word
      vx_pkg::ALU_MIN: begin
        y = lt_s ? a : b;
      end
      vx_pkg::ALU_MINU: begin
        y = lt_u ? a : b;
      end
      vx_pkg::ALU_MAX: begin
        y = lt_s ? b : a;
      end
      default: begin
        y = lt_u ? b : a;
      end
    endcase
  end

endmodule

//--- rtl/vec_addr_gen.sv
module vec_addr_gen (
  input  vx_pkg::ls_mode_e                            mode,
  input  vx_pkg::eew_e                                eew,
  input  logic [2:0]                                  nf,
  input  logic [2:0]                                  nf_count,
  input  logic [vx_pkg::XLEN-1:0]                     xs1,
  input  logic [vx_pkg::XLEN-1:0]                     xs2,
  input  logic [vx_pkg::NLANES-1:0][vx_pkg::XLEN-1:0] index,
  output logic [vx_pkg::NLANES-1:0][vx_pkg::XLEN-1:0] addr
);

  logic [1:0]              eew_shift;
  logic [vx_pkg::XLEN-1:0] eew_bytes;
  logic [vx_pkg::XLEN-1:0] nf_ext;
  logic [vx_pkg::XLEN-1:0] nf_count_ext;
  logic [vx_pkg::XLEN-1:0] seg_base;
  logic [vx_pkg::XLEN-1:0] seg_stride;

  // element size as a shift, bytes = 1 << shift
  always_comb begin
    case (eew)
      vx_pkg::EEW8:  eew_shift = 2'd0;
      vx_pkg::EEW16: eew_shift = 2'd1;
      default:       eew_shift = 2'd2;
    endcase
  end

  assign nf_ext       = {{(vx_pkg::XLEN-3){1'b0}}, nf};
  assign nf_count_ext = {{(vx_pkg::XLEN-3){1'b0}}, nf_count};
  assign eew_bytes    = {{(vx_pkg::XLEN-1){1'b0}}, 1'b1} << eew_shift;

  // field offset inside a segment, and distance between segments
  assign seg_base   = nf_count_ext << eew_shift;
  assign seg_stride = (nf_ext + 1'b1) << eew_shift;

  always_comb begin
    case (mode)
      vx_pkg::LS_UNIT: begin
        addr[0] = xs1;
        addr[1] = xs1 + eew_bytes;
      end
      vx_pkg::LS_STRIDED: begin
        addr[0] = xs1;
        addr[1] = xs1 + xs2;
      end
      vx_pkg::LS_INDEXED: begin
        for (int i = 0; i < vx_pkg::NLANES; i++) begin
          addr[i] = xs1 + (index[i] << eew_shift);
        end
      end
      default: begin
        addr[0] = xs1 + seg_base;
        addr[1] = xs1 + seg_base + seg_stride;
      end
    endcase
  end

endmodule

//--- rtl/vec_decode.sv
module vec_decode (
  input  logic                                       CLK,
  input  logic                                       nRST,
  input  logic                                       cmd_valid,
  input  vx_pkg::cmd_u                               cmd,
  input  logic [vx_pkg::NLANES-1:0][vx_pkg::XLEN-1:0] vs1,
  input  logic [vx_pkg::NLANES-1:0][vx_pkg::XLEN-1:0] vs2,
  input  logic [vx_pkg::XLEN-1:0]                    xs1,
  input  logic [vx_pkg::XLEN-1:0]                    xs2,
  output logic                                       dec_valid,
  output vx_pkg::dec_t                               dec
);

  vx_pkg::dec_t            dec_next;
  logic [vx_pkg::XLEN-1:0] imm_ext;

  assign imm_ext = {{(vx_pkg::XLEN-vx_pkg::IMM_W){cmd.alu.imm[vx_pkg::IMM_W-1]}},
                    cmd.alu.imm};

  always_comb begin
    dec_next     = '0;
    // index and a-operand come straight from vs2
    dec_next.op2 = vs2;
    dec_next.xs1 = xs1;
    dec_next.xs2 = xs2;
    if (cmd.mem.kind) begin
      dec_next.is_mem   = 1'b1;
      dec_next.is_store = cmd.mem.is_store;
      dec_next.mode     = cmd.mem.mode;
      dec_next.eew      = cmd.mem.eew;
      dec_next.nf       = cmd.mem.nf;
      dec_next.nf_count = cmd.mem.nf_count;
      dec_next.vd       = cmd.mem.vd;
      // no reduction or scalar write for loads and stores
    end else begin
      dec_next.aluop     = cmd.alu.aluop;
      dec_next.sew       = cmd.alu.sew;
      dec_next.reduce    = cmd.alu.reduce;
      dec_next.to_scalar = cmd.alu.to_scalar;
      dec_next.vd        = cmd.alu.vd;
      for (int i = 0; i < vx_pkg::NLANES; i++) begin
        case (cmd.alu.src1)
          vx_pkg::SRC_V: dec_next.op1[i] = vs1[i];
          vx_pkg::SRC_I: dec_next.op1[i] = imm_ext;
          vx_pkg::SRC_X: dec_next.op1[i] = xs1;
          default:       dec_next.op1[i] = '0;
        endcase
      end
    end
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      dec_valid <= 1'b0;
      dec       <= '0;
    end else begin
      dec_valid <= cmd_valid;
      if (cmd_valid) begin
        dec <= dec_next;
      end
    end
  end

endmodule

//--- rtl/vec_execute.sv
module vec_execute (
  input  logic         CLK,
  input  logic         nRST,
  input  logic         dec_valid,
  input  vx_pkg::dec_t dec,
  output logic         exe_valid,
  output vx_pkg::exe_t exe
);

  logic [vx_pkg::NLANES-1:0][vx_pkg::XLEN-1:0] alu_y;
  logic [vx_pkg::NLANES-1:0][vx_pkg::XLEN-1:0] addr;
  logic [vx_pkg::NLANES-1:0][vx_pkg::XLEN-1:0] lane_val;
  vx_pkg::exe_t                                exe_next;

  // one ALU per lane, a is vs2 and b is the selected op1
  for (genvar gi = 0; gi < vx_pkg::NLANES; gi++) begin : g_lane
    vec_lane_alu u_alu (
      .aluop (dec.aluop),
      .sew   (dec.sew),
      .a     (dec.op2[gi]),
      .b     (dec.op1[gi]),
      .y     (alu_y[gi])
    );
  end

  vec_addr_gen u_agen (
    .mode     (dec.mode),
    .eew      (dec.eew),
    .nf       (dec.nf),
    .nf_count (dec.nf_count),
    .xs1      (dec.xs1),
    .xs2      (dec.xs2),
    .index    (dec.op2),
    .addr     (addr)
  );

  assign lane_val = dec.is_mem ? addr : alu_y;

  always_comb begin
    exe_next           = '0;
    exe_next.lane0     = lane_val[0];
    exe_next.lane1     = lane_val[1];
    exe_next.is_mem    = dec.is_mem;
    exe_next.is_store  = dec.is_store;
    exe_next.aluop     = dec.aluop;
    exe_next.sew       = dec.sew;
    exe_next.reduce    = dec.reduce;
    exe_next.to_scalar = dec.to_scalar;
    exe_next.vd        = dec.vd;
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      exe_valid <= 1'b0;
      exe       <= '0;
    end else begin
      exe_valid <= dec_valid;
      if (dec_valid) begin
        exe <= exe_next;
      end
    end
  end

endmodule

//--- rtl/vec_result.sv
module vec_result (
  input  logic         CLK,
  input  logic         nRST,
  input  logic         exe_valid,
  input  vx_pkg::exe_t exe,
  output logic         out_valid,
  output vx_pkg::res_t out
);

  logic [vx_pkg::XLEN-1:0] fold_y;
  logic [vx_pkg::XLEN-1:0] data0;
  vx_pkg::res_t            out_next;

  // same lane ALU, used to combine the two lanes
  vec_lane_alu u_fold (
    .aluop (exe.aluop),
    .sew   (exe.sew),
    .a     (exe.lane0),
    .b     (exe.lane1),
    .y     (fold_y)
  );

  assign data0 = exe.reduce ? fold_y : exe.lane0;

  always_comb begin
    out_next          = '0;
    out_next.data0    = data0;
    out_next.data1    = exe.lane1;
    out_next.is_mem   = exe.is_mem;
    out_next.is_store = exe.is_store;
    out_next.vd       = exe.vd;
    // scalar write-back takes lane 0 after the fold
    out_next.rd_wen   = exe.to_scalar;
    if (exe.to_scalar) begin
      out_next.rd_data = data0;
    end
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      out_valid <= 1'b0;
      out       <= '0;
    end else begin
      out_valid <= exe_valid;
      if (exe_valid) begin
        out <= out_next;
      end
    end
  end

endmodule

//--- rtl/vec_exec_top.sv
module vec_exec_top (
  input  logic                                       CLK,
  input  logic                                       nRST,
  input  logic                                       cmd_valid,
  input  vx_pkg::cmd_u                               cmd,
  input  logic [vx_pkg::NLANES-1:0][vx_pkg::XLEN-1:0] vs1,
  input  logic [vx_pkg::NLANES-1:0][vx_pkg::XLEN-1:0] vs2,
  input  logic [vx_pkg::XLEN-1:0]                    xs1,
  input  logic [vx_pkg::XLEN-1:0]                    xs2,
  output logic                                       out_valid,
  output vx_pkg::res_t                               out
);

  logic         dec_valid;
  vx_pkg::dec_t dec;
  logic         exe_valid;
  vx_pkg::exe_t exe;

  vec_decode u_decode (
    .CLK       (CLK),
    .nRST      (nRST),
    .cmd_valid (cmd_valid),
    .cmd       (cmd),
    .vs1       (vs1),
    .vs2       (vs2),
    .xs1       (xs1),
    .xs2       (xs2),
    .dec_valid (dec_valid),
    .dec       (dec)
  );

  vec_execute u_execute (
    .CLK       (CLK),
    .nRST      (nRST),
    .dec_valid (dec_valid),
    .dec       (dec),
    .exe_valid (exe_valid),
    .exe       (exe)
  );

  // three registered stages, out_valid lands 3 cycles after cmd_valid
  vec_result u_result (
    .CLK       (CLK),
    .nRST      (nRST),
    .exe_valid (exe_valid),
    .exe       (exe),
    .out_valid (out_valid),
    .out       (out)
  );

endmodule

//--- bench/vec_exec_tb.sv
module vec_exec_tb;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int NTESTS  = 23;
  localparam int NCOLS   = 12;
  localparam int LATENCY = 3;
  localparam int TIMEOUT = 20;

  typedef struct packed {
    logic [31:0]  tag;
    logic [31:0]  issued;
    vx_pkg::res_t res;
  } expect_t;

  logic                                        CLK;
  logic                                        nRST;
  logic                                        cmd_valid;
  vx_pkg::cmd_u                                cmd;
  logic [vx_pkg::NLANES-1:0][vx_pkg::XLEN-1:0] vs1;
  logic [vx_pkg::NLANES-1:0][vx_pkg::XLEN-1:0] vs2;
  logic [vx_pkg::XLEN-1:0]                     xs1;
  logic [vx_pkg::XLEN-1:0]                     xs2;
  logic                                        out_valid;
  vx_pkg::res_t                                out;

  logic [31:0] vectors [NTESTS*NCOLS];
  expect_t     pending [$];
  logic [31:0] cycle  = '0;
  int          n_done = 0;

  vec_exec_top dut0 (
    .CLK       (CLK),
    .nRST      (nRST),
    .cmd_valid (cmd_valid),
    .cmd       (cmd),
    .vs1       (vs1),
    .vs2       (vs2),
    .xs1       (xs1),
    .xs2       (xs2),
    .out_valid (out_valid),
    .out       (out)
  );

  initial begin
    CLK = 1'b0;
    forever #2 CLK = ~CLK;
  end

  always @(posedge CLK) begin
    cycle <= cycle + 32'd1;
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Regression failed");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_field(input string field, input logic [31:0] tag,
                             input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
      $display("ERROR test %h %s: expected %h actual %h", tag, field, exp, act);
      abort_run("result mismatch");
    end
  endtask

  // is_mem, is_store and vd follow straight from the command fields
  function automatic expect_t expected_for(input int idx, input logic [31:0] now);
    expect_t     e;
    logic [31:0] c;
    int          base;
    base             = idx * NCOLS;
    c                = vectors[base+1];
    e                = '0;
    e.tag            = vectors[base];
    e.issued         = now;
    e.res.data0      = vectors[base+8];
    e.res.data1      = vectors[base+9];
    e.res.rd_wen     = vectors[base+10][0];
    e.res.rd_data    = vectors[base+11];
    e.res.is_mem     = c[31];
    if (c[31]) begin
      e.res.is_store = c[30];
      e.res.vd       = c[19:15];
    end else begin
      e.res.vd       = c[16:12];
    end
    return e;
  endfunction

  task automatic drive_command(input int idx);
    int base;
    base      = idx * NCOLS;
    cmd       = vectors[base+1];
    vs1[0]    = vectors[base+2];
    vs1[1]    = vectors[base+3];
    vs2[0]    = vectors[base+4];
    vs2[1]    = vectors[base+5];
    xs1       = vectors[base+6];
    xs2       = vectors[base+7];
    cmd_valid = 1'b1;
    pending.push_back(expected_for(idx, cycle));
  endtask

  task automatic compare_result(input expect_t e);
    check_field("data0", e.tag, e.res.data0, out.data0);
    check_field("data1", e.tag, e.res.data1, out.data1);
    check_field("rd_data", e.tag, e.res.rd_data, out.rd_data);
    check_field("vd", e.tag, {27'h0, e.res.vd}, {27'h0, out.vd});
    check_field("is_mem", e.tag, {31'h0, e.res.is_mem}, {31'h0, out.is_mem});
    check_field("is_store", e.tag, {31'h0, e.res.is_store}, {31'h0, out.is_store});
    check_field("rd_wen", e.tag, {31'h0, e.res.rd_wen}, {31'h0, out.rd_wen});
    check_field("latency", e.tag, LATENCY, cycle - e.issued);
  endtask

  // outputs are registered, so the falling edge sees them settled
  initial begin
    expect_t head;
    forever begin
      @(negedge CLK);
      if (out_valid) begin
        if (pending.size() == 0) begin
          abort_run("out_valid rose with no command in flight");
        end else begin
          head = pending.pop_front();
          compare_result(head);
          n_done++;
        end
      end else if (pending.size() != 0 && cycle - pending[0].issued > TIMEOUT) begin
        abort_run("timed out waiting for out_valid of a command in flight");
      end
    end
  end

  initial begin
    int gap;
    int wait_cycles;
    void'($urandom(32'hcf7e));
    $readmemh("bench/vec_exec_testdata.txt", vectors);
    nRST      = 1'b0;
    cmd_valid = 1'b0;
    cmd       = '0;
    vs1       = '0;
    vs2       = '0;
    xs1       = '0;
    xs2       = '0;
    repeat (2) @(negedge CLK);
    nRST = 1'b1;
    // idle pipeline must stay quiet
    repeat (6) begin
      @(negedge CLK);
      check_field("idle", 32'h0, 32'h0, {31'h0, out_valid});
    end
    // last few go back to back
    for (int i = 0; i < NTESTS; i++) begin
      drive_command(i);
      @(negedge CLK);
      cmd_valid = 1'b0;
      gap = (i >= NTESTS - 6) ? 0 : $urandom % 3;
      repeat (gap) @(negedge CLK);
    end
    wait_cycles = 0;
    while (n_done < NTESTS && wait_cycles < TIMEOUT) begin
      @(posedge CLK);
      wait_cycles++;
    end
    if (n_done == NTESTS && pending.size() == 0) begin
      $display("Regression passed");
      $finish;
    end else begin
      abort_run("timed out before every command produced a result");
    end
  end

endmodule

//--- verilog.f
rtl/vx_pkg.sv
rtl/vec_lane_alu.sv
rtl/vec_addr_gen.sv
rtl/vec_decode.sv
rtl/vec_execute.sv
rtl/vec_result.sv
rtl/vec_exec_top.sv
bench/vec_exec_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing -f verilog.f --top-module vec_exec_tb -Mdir obj_dir -o vec_exec_sim
./obj_dir/vec_exec_sim > sim.log 2>&1 || true
cat sim.log
if grep -q "Regression failed" sim.log; then
  exit 1
fi
grep -q "Regression passed" sim.log

//--- bench/vec_exec_testdata.txt
// tag cmd vs1[0] vs1[1] vs2[0] vs2[1] xs1 xs2 then expected data0 data1 rd_wen rd_data
// tags 01xx are ALU commands, 02xx are loads and stores
0101 02001000 00000010 00000020 00000003 00000004 00000000 00000000 00000013 00000024 0 00000000
0102 162C2000 AAAAAAAA 55555555 0000FFFF 12345678 00000000 00000000 0000FFF6 12345670 0 00000000
0103 2A003000 00000000 00000000 0000000F 0F000000 F0F00000 00000000 F0F0000F FFF00000 0 00000000
0104 32004000 FFFF0000 12345678 0F0F0F0F 12345678 00000000 00000000 F0F00F0F 00000000 0 00000000
0105 0E005000 11111111 22222222 00000007 00000009 00000000 00000000 00000007 00000009 0 00000000
0106 40006000 00000010 000000FE 000000F0 12345605 00000000 00000000 000000F0 000000FE 0 00000000
0107 60007000 00000010 000000FE 000000F0 12345605 00000000 00000000 00000010 12345605 0 00000000
0108 41008000 00017FFF 0000FF00 00008000 00000100 00000000 00000000 00008000 0000FF00 0 00000000
0109 61009000 00017FFF 0000FF00 00008000 00000100 00000000 00000000 00017FFF 00000100 0 00000000
010A 4200A000 00000001 FFFFFFFF 80000000 7FFFFFFF 00000000 00000000 80000000 FFFFFFFF 0 00000000
010B 5200B000 00000001 FFFFFFFF 80000000 7FFFFFFF 00000000 00000000 00000001 7FFFFFFF 0 00000000
010C 7A00C000 00000000 00000000 00000FFF 00001001 00001000 00000000 00001000 00001001 0 00000000
010D 661ED000 00000000 00000000 FFFFFFF0 00000020 00000000 00000000 0000000F 00000020 0 00000000
010E 02C0E000 00000001 00000002 00000010 00000020 00000000 00000000 00000033 00000022 1 00000033
010F 6080F000 00000005 000000F0 00000003 00000080 00000000 00000000 00000005 000000F0 0 00000000
0110 5AC10000 00000000 00000000 00000200 00000050 00000100 00000000 00000050 00000050 1 00000050
0201 80008000 00000000 00000000 00000000 00000000 00001000 00000000 00001000 00001001 0 00000000
0202 C8010000 00000000 00000000 00000000 00000000 00002000 00000000 00002000 00002004 0 00000000
0203 94018000 00000000 00000000 00000000 00000000 00003000 00000040 00003000 00003040 0 00000000
0204 E4020000 00000000 00000000 00000003 00000010 00004000 00000000 00004006 00004020 0 00000000
0205 A8028000 00000000 00000000 00000001 00000100 00005000 00000000 00005004 00005400 0 00000000
0206 B5130000 00000000 00000000 00000000 00000000 00006000 00000000 00006002 00006008 0 00000000
0207 F9A38000 00000000 00000000 00000000 00000000 00007000 00000000 00007008 00007018 0 00000000
